//--- Bender.yml
package:
  name: lsu_unit

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lsu_pkg.sv
      - verilog/lsu_req_align.sv
      - verilog/lsu_load_align.sv
      - verilog/lsu_ctrl_fsm.sv
      - verilog/lsu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/lsu_props.sv
      - bench/lsu_tb.sv

//--- bench/lsu_props.sv
////////////////////
// memory protocol properties bound into the lsu top level
////////////////////
`timescale 1ns/1ps

module lsu_props (
  input logic                clk,
  input logic                rst_n,
  input lsu_pkg::lsu_state_e state_q,     // controller state
  input logic                data_req_o,
  input logic                data_gnt_i,
  input logic                data_rvalid_i,
  input lsu_pkg::lsu_word_t  data_addr_o
);

  int fail_cnt = 0; // number of failed properties

  // a response needs a granted access, which leaves IDLE
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == lsu_pkg::IDLE) |-> !data_rvalid_i)
    else
    begin
      $error("rvalid arrived while the controller was idle");
      fail_cnt++;
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    data_gnt_i |-> data_req_o) // memory grants only what was asked
    else
    begin
      $error("gnt arrived without a request");
      fail_cnt++;
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    data_req_o |-> !$isunknown(data_addr_o))
    else
    begin
      $error("address has unknown bits during a request");
      fail_cnt++;
    end

endmodule

bind lsu_top lsu_props u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .state_q       (u_ctrl_fsm.state_q),
  .data_req_o    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .data_addr_o   (data_addr_o)
);

//--- bench/lsu_tb.sv
////////////////////
// lsu testbench with a 64-word memory and random grant delay
// rvalid follows gnt by one cycle, a store with err writes nothing
////////////////////
`timescale 1ns/1ps

module lsu_tb;

  localparam int NROWS = 25;
  localparam int LIMIT = 12 * NROWS + 20; // cycle budget for the whole run

  typedef struct packed {
    logic               we;
    lsu_pkg::lsu_size_t size;
    logic               sign;
    lsu_pkg::lsu_word_t opa;
    lsu_pkg::lsu_word_t opb;
    logic               inc;   // address is opa + opb
    lsu_pkg::lsu_off_t  roff;  // register offset of store data
    lsu_pkg::lsu_word_t wdata;
    logic [3:0]         stall; // cycles with ex_valid low
    lsu_pkg::lsu_be_t   be;    // phase one enable
    lsu_pkg::lsu_word_t rdata;
    logic               err;   // forced bus error, expected error output
  } row_t;

  row_t tbl [NROWS];

  logic clk, rst_n;
  logic data_req, data_gnt, data_rvalid, data_err, data_we;
  lsu_pkg::lsu_word_t data_addr, data_wdata, data_rdata, rdata_ex, opa, opb, wdata_ex;
  lsu_pkg::lsu_be_t data_be;
  lsu_pkg::lsu_size_t type_ex;
  lsu_pkg::lsu_off_t roff_ex;
  logic we_ex, sign_ex, req_ex, useincr, mis_ex, mis_o;
  logic load_err, store_err, ready_ex, ready_wb, ex_valid, busy;

  lsu_pkg::lsu_word_t mem [64];
  logic [31:0] rng;
  logic [1:0] wait_cnt, wait_tgt;
  logic force_err, s_gnt, s_req, s_we, s_err;
  lsu_pkg::lsu_word_t s_addr, s_wdata;
  lsu_pkg::lsu_be_t s_be;
  int stall_left, cycles, errors;

  lsu_top u_dut (
    .clk(clk), .rst_n(rst_n),
    .data_req_o(data_req), .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid),
    .data_err_i(data_err), .data_addr_o(data_addr), .data_we_o(data_we),
    .data_be_o(data_be), .data_wdata_o(data_wdata), .data_rdata_i(data_rdata),
    .data_we_ex_i(we_ex), .data_type_ex_i(type_ex), .data_wdata_ex_i(wdata_ex),
    .data_reg_offset_ex_i(roff_ex), .data_sign_ext_ex_i(sign_ex),
    .data_rdata_ex_o(rdata_ex), .data_req_ex_i(req_ex), .operand_a_ex_i(opa),
    .operand_b_ex_i(opb), .addr_useincr_ex_i(useincr), .data_misaligned_ex_i(mis_ex),
    .data_misaligned_o(mis_o), .load_err_o(load_err), .store_err_o(store_err),
    .lsu_ready_ex_o(ready_ex), .lsu_ready_wb_o(ready_wb), .ex_valid_i(ex_valid),
    .busy_o(busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //////////////////// memory model
  assign data_gnt = data_req && (wait_cnt == wait_tgt); // grant after 0 to 2 cycles
  assign data_err = data_gnt && force_err;

  always @(posedge clk)
  begin
    s_gnt = data_gnt;   // sample at the edge, update 1 ns later
    s_req = data_req;
    s_err = data_err;
    s_we = data_we;
    s_addr = data_addr;
    s_be = data_be;
    s_wdata = data_wdata;
    #1;
    if (!rst_n)
    begin
      data_rvalid = 1'b0;
      wait_cnt = 2'd0;
    end
    else
    begin
      data_rvalid = s_gnt;
      if (s_gnt)
      begin
        wait_cnt = 2'd0;
        rng = xorshift(rng);
        wait_tgt = rng % 3;
        if (!s_we)
          data_rdata = mem[s_addr[7:2]];
        else if (!s_err)
          for (int b = 0; b < 4; b++)
            if (s_be[b])
              mem[s_addr[7:2]][8*b +: 8] = s_wdata[8*b +: 8];
      end
      else if (s_req)
        wait_cnt = wait_cnt + 2'd1; // still waiting for gnt
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("timeout: the run went past its cycle limit");
      $display("tests failed");
      $fatal(1, "run stopped by timeout");
    end
  end

  //////////////////// checks
  task automatic stop_on_error();
    errors++;
    $display("tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // the bound checker counts its own assertion failures
  always @(negedge clk)
  begin
    assert (u_dut.u_props.fail_cnt == 0)
    else
    begin
      $display("a memory protocol property of the bound checker failed");
      stop_on_error();
    end
  end

  // one clock with ex_valid following the stall count
  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (stall_left > 0)
      stall_left--;
    ex_valid = (stall_left == 0);
  endtask

  // one memory access from request to rvalid
  task automatic do_phase(input int i, input bit second, input logic [31:0] addr,
                          output bit split);
    logic [3:0] be_exp;
    logic mis_exp;
    be_exp = tbl[i].be;
    if (second)
      be_exp = (tbl[i].size == 2'd0) ? ~tbl[i].be : 4'b0001; // spilled lanes
    mis_exp = !second && (((tbl[i].size == 2'd0) && (addr[1:0] != 2'd0)) ||
                          ((tbl[i].size == 2'd1) && (addr[1:0] == 2'd3)));
    @(negedge clk);
    while (!data_gnt)
    begin
      check("lsu_ready_ex_o", ready_ex, 1'b0); // EX waits for gnt
      next_cycle();
      @(negedge clk);
    end
    check("data_addr_o", data_addr, addr);
    check("data_be_o", data_be, be_exp);
    check("lsu_ready_ex_o", ready_ex, 1'b1);
    check("data_misaligned_o", mis_o, mis_exp);
    check("load_err_o", load_err, tbl[i].err && !tbl[i].we);
    check("store_err_o", store_err, tbl[i].err && tbl[i].we);
    split = mis_o;
    next_cycle();
    if (!split)
    begin
      req_ex = 1'b0;  // phase one keeps its inputs until rvalid
      mis_ex = 1'b0;
    end
    @(negedge clk);
    while (!data_rvalid)
    begin
      if (tbl[i].stall == 0)
        check("lsu_ready_wb_o", ready_wb, 1'b0);
      if (!ex_valid)
        check("busy_o", busy, 1'b1);
      next_cycle();
      @(negedge clk);
    end
    if (tbl[i].stall == 0)
      check("lsu_ready_wb_o", ready_wb, 1'b1);
    if (!split && !tbl[i].we && !tbl[i].err)
      check("data_rdata_ex_o", rdata_ex, tbl[i].rdata);
  endtask

  task automatic run_row(input int i);
    logic [31:0] base;
    bit split;
    base = tbl[i].inc ? tbl[i].opa + tbl[i].opb : tbl[i].opa;
    @(posedge clk);
    #1;
    we_ex = tbl[i].we;
    type_ex = tbl[i].size;
    sign_ex = tbl[i].sign;
    opa = tbl[i].opa;
    opb = tbl[i].opb;
    useincr = tbl[i].inc;
    roff_ex = tbl[i].roff;
    wdata_ex = tbl[i].wdata;
    force_err = tbl[i].err;
    req_ex = 1'b1;
    mis_ex = 1'b0;
    stall_left = tbl[i].stall;
    ex_valid = (stall_left == 0);
    do_phase(i, 1'b0, base, split);
    if (split)
    begin
      next_cycle();
      mis_ex = 1'b1;  // phase two at the next word, same low bits
      opa = base + 32'd4;
      useincr = 1'b0;
      do_phase(i, 1'b1, base + 32'd4, split);
    end
    next_cycle();
    req_ex = 1'b0;
    mis_ex = 1'b0;
    while (!ex_valid)
    begin
      @(negedge clk);
      check("busy_o", busy, 1'b1); // held by the EX stall
      next_cycle();
    end
    next_cycle();
    @(negedge clk);
    check("busy_o", busy, 1'b0);
    check("data_req_o", data_req, 1'b0);
    if (!tbl[i].we && !tbl[i].err)
      check("data_rdata_ex_o", rdata_ex, tbl[i].rdata); // held after rvalid
  endtask

  //////////////////// stimulus table
  // we size sign opa opb inc roff wdata stall be rdata err
  task automatic load_table();
    tbl[0]  = '{1, 0, 0, 'h10, 0, 0, 0, 'h8F7EC13A, 0, 'hF, 0, 0};
    tbl[1]  = '{0, 0, 0, 'h0C, 4, 1, 0, 0, 0, 'hF, 'h8F7EC13A, 0};
    tbl[2]  = '{0, 2, 0, 'h10, 0, 0, 0, 0, 0, 'h1, 'h0000003A, 0};
    tbl[3]  = '{0, 2, 1, 'h11, 0, 0, 0, 0, 0, 'h2, 'hFFFFFFC1, 0};
    tbl[4]  = '{0, 2, 0, 'h12, 0, 0, 0, 0, 0, 'h4, 'h0000007E, 0};
    tbl[5]  = '{0, 2, 1, 'h13, 0, 0, 0, 0, 0, 'h8, 'hFFFFFF8F, 0};
    tbl[6]  = '{0, 3, 0, 'h13, 0, 0, 0, 0, 0, 'h8, 'h0000008F, 0};
    tbl[7]  = '{0, 1, 1, 'h10, 0, 0, 0, 0, 0, 'h3, 'hFFFFC13A, 0};
    tbl[8]  = '{0, 1, 0, 'h11, 0, 0, 0, 0, 0, 'h6, 'h00007EC1, 0};
    tbl[9]  = '{0, 1, 1, 'h12, 0, 0, 0, 0, 0, 'hC, 'hFFFF8F7E, 0};
    tbl[10] = '{0, 1, 0, 'h12, 0, 0, 0, 0, 0, 'hC, 'h00008F7E, 0};
    tbl[11] = '{1, 0, 0, 'h20, 0, 0, 0, 0, 0, 'hF, 0, 0};
    tbl[12] = '{1, 2, 0, 'h21, 0, 0, 2, 'h44332211, 0, 'h2, 0, 0};
    tbl[13] = '{1, 1, 0, 'h22, 0, 0, 0, 'h0000BEEF, 0, 'hC, 0, 0};
    tbl[14] = '{1, 2, 0, 'h20, 0, 0, 3, 'h5A000000, 0, 'h1, 0, 0};
    tbl[15] = '{0, 0, 0, 'h20, 0, 0, 0, 0, 0, 'hF, 'hBEEF335A, 0};
    tbl[16] = '{1, 0, 0, 'h31, 0, 0, 0, 'hDDCCBBAA, 0, 'hE, 0, 0};
    tbl[17] = '{0, 0, 0, 'h31, 0, 0, 0, 0, 0, 'hE, 'hDDCCBBAA, 0};
    tbl[18] = '{1, 1, 0, 'h43, 0, 0, 0, 'h00009876, 0, 'h8, 0, 0};
    tbl[19] = '{0, 1, 1, 'h43, 0, 0, 0, 0, 0, 'h8, 'hFFFF9876, 0};
    tbl[20] = '{0, 0, 0, 'h10, 0, 0, 0, 0, 6, 'hF, 'h8F7EC13A, 0};
    tbl[21] = '{1, 0, 0, 'h18, 0, 0, 0, 'h12345678, 5, 'hF, 0, 0};
    tbl[22] = '{0, 0, 0, 'h18, 0, 0, 0, 0, 0, 'hF, 0, 1};
    tbl[23] = '{1, 0, 0, 'h18, 0, 0, 0, 'hFFFFFFFF, 0, 'hF, 0, 1};
    tbl[24] = '{0, 0, 0, 'h18, 0, 0, 0, 0, 0, 'hF, 'h12345678, 0};
  endtask

  initial
  begin
    rng = 32'h7199_7534;
    cycles = 0;
    errors = 0;
    stall_left = 0;
    rst_n = 1'b0;
    req_ex = 1'b0;
    we_ex = 1'b0;
    sign_ex = 1'b0;
    useincr = 1'b0;
    mis_ex = 1'b0;
    force_err = 1'b0;
    type_ex = '0;
    roff_ex = '0;
    opa = '0;
    opb = '0;
    wdata_ex = '0;
    data_rdata = '0;
    data_rvalid = 1'b0;
    wait_cnt = 2'd0;
    wait_tgt = 2'd0;
    ex_valid = 1'b1;
    for (int k = 0; k < 64; k++)
      mem[k] = 32'hC3A5_0F00 ^ (k * 32'h0105_0B11); // differs per word address
    load_table();
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    check("data_req_o", data_req, 1'b0);
    check("busy_o", busy, 1'b0);
    check("load_err_o", load_err, 1'b0);
    check("store_err_o", store_err, 1'b0);
    check("lsu_ready_ex_o", ready_ex, 1'b1);
    check("lsu_ready_wb_o", ready_wb, 1'b1);
    check("data_misaligned_o", mis_o, 1'b0);
    check("data_rdata_ex_o", rdata_ex, 32'h0);
    for (int i = 0; i < NROWS; i++)
      run_row(i);
    if (errors == 0 && u_dut.u_props.fail_cnt == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_req_align.sv
verilog/lsu_load_align.sv
verilog/lsu_ctrl_fsm.sv
verilog/lsu_top.sv
bench/lsu_props.sv
bench/lsu_tb.sv

//--- verilog/lsu_config.svh
////////////////////
// lsu datapath widths
// the lane logic is written for 32-bit words with four byte lanes only
////////////////////
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data and address width
`define LSU_DATA_W 32

// byte lanes per word
`define LSU_BE_W 4

// byte offset inside a word
`define LSU_OFF_W 2

`endif

//--- verilog/lsu_ctrl_fsm.sv
////////////////////
// lsu request controller, one access in flight at a time
// new requests are taken from IDLE only
////////////////////
`timescale 1ns/1ps

module lsu_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,

  input  logic data_req_ex_i,  // EX wants an access
  input  logic data_gnt_i,     // memory grant
  input  logic data_rvalid_i,  // memory response
  input  logic data_err_i,     // bus error, valid with gnt
  input  logic data_we_i,      // access is a store
  input  logic ex_valid_i,     // EX stage moves on this cycle

  output logic data_req_o,
  output logic lsu_ready_ex_o, // EX may leave the access
  output logic lsu_ready_wb_o, // WB has its load data
  output logic busy_o,
  output logic load_err_o,
  output logic store_err_o
);

  lsu_pkg::lsu_state_e state_q;
  lsu_pkg::lsu_state_e state_d;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= lsu_pkg::IDLE;
    else
      state_q <= state_d;
  end

  //////////////////// next state and outputs
  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      lsu_pkg::IDLE:
      begin
        data_req_o = data_req_ex_i;      // no register between EX and memory
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;   // EX stalls until granted
          if (data_gnt_i)
            state_d = ex_valid_i ? lsu_pkg::WAIT_RVALID : lsu_pkg::WAIT_RVALID_EX_STALL;
        end
      end

      lsu_pkg::WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;
        lsu_ready_ex_o = !data_req_ex_i; // a next request waits for IDLE
        if (data_rvalid_i)
          state_d = lsu_pkg::IDLE;
      end

      lsu_pkg::WAIT_RVALID_EX_STALL:
      begin
        if (data_rvalid_i)
          state_d = ex_valid_i ? lsu_pkg::IDLE : lsu_pkg::IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = lsu_pkg::WAIT_RVALID; // stall over, response still due
      end

      lsu_pkg::IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = lsu_pkg::IDLE;
      end

      default:
      begin
        state_d = lsu_pkg::IDLE;
      end
    endcase
  end

  //////////////////// status
  assign busy_o      = (state_q != lsu_pkg::IDLE) || data_req_o;
  assign load_err_o  = data_gnt_i && data_err_i && !data_we_i;
  assign store_err_o = data_gnt_i && data_err_i && data_we_i;

endmodule

//--- verilog/lsu_load_align.sv
////////////////////
// load side of the lsu, attributes are captured at grant
// one access outstanding only, the registered attributes belong to it
////////////////////
`timescale 1ns/1ps

module lsu_load_align (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               data_gnt_i,      // memory took the request
  input  logic               data_rvalid_i,   // read data valid this cycle

  input  lsu_pkg::lsu_off_t  addr_off_i,      // byte offset of the current request
  input  lsu_pkg::lsu_size_t data_type_i,     // size of the current request
  input  logic               sign_ext_i,      // sign extend halfwords and bytes
  input  logic               data_we_i,       // current request is a store
  input  logic               misaligned_ex_i, // EX is in phase two
  input  logic               misaligned_o_i,  // phase one flagged by the request side

  input  lsu_pkg::lsu_word_t data_rdata_i,    // raw memory word
  output lsu_pkg::lsu_word_t rdata_o          // aligned and extended load data
);

  // attributes of the granted access
  lsu_pkg::lsu_size_t type_q;
  lsu_pkg::lsu_off_t  off_q;
  logic               sign_q;
  logic               we_q;

  lsu_pkg::lsu_word_t hold_q;     // last result, or raw word of phase one
  logic [63:0]        join_win;   // new word above the held word
  lsu_pkg::lsu_word_t lanes;      // new word shifted down to lane 0
  logic [15:0]        half_sel;
  logic [7:0]         byte_sel;
  lsu_pkg::lsu_word_t rdata_ext;  // result for the register file

  //////////////////// attributes
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q <= '0;
      off_q  <= '0;
      sign_q <= 1'b0;
      we_q   <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      type_q <= data_type_i;
      off_q  <= addr_off_i;  // same low bits in both phases
      sign_q <= sign_ext_i;
      we_q   <= data_we_i;
    end
  end

  //////////////////// lane selection
  // for a split access the held word carries the low bytes and the
  // new word the high bytes, so shifting the pair down by the offset
  // lines the value up at bit 0
  assign join_win = {data_rdata_i, hold_q} >> {off_q, 3'b000};
  assign lanes    = data_rdata_i >> {off_q, 3'b000};

  // offset 3 halfword takes held byte 3 and new byte 0
  assign half_sel = (off_q == 2'b11) ? join_win[15:0] : lanes[15:0];
  assign byte_sel = lanes[7:0];

  //////////////////// extension
  always_comb
  begin
    case (type_q)
      2'b00:
      begin
        // aligned word passes, otherwise the two halves are joined
        if (off_q == 2'b00)
          rdata_ext = data_rdata_i;
        else
          rdata_ext = join_win[31:0];
      end

      2'b01:
      begin
        rdata_ext = {{16{sign_q & half_sel[15]}}, half_sel};
      end

      default:
      begin
        rdata_ext = {{24{sign_q & byte_sel[7]}}, byte_sel};
      end
    endcase
  end

  //////////////////// hold register
  // stores are ignored, their response carries no data
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      hold_q <= '0;
    end
    else if (data_rvalid_i && !we_q)
    begin
      if (misaligned_ex_i || misaligned_o_i)
        hold_q <= data_rdata_i; // raw word, joined when phase two returns
      else
        hold_q <= rdata_ext;    // final value, held for the WB stage
    end
  end

  // live data in the response cycle, held value otherwise
  assign rdata_o = data_rvalid_i ? rdata_ext : hold_q;

endmodule

//--- verilog/lsu_pkg.sv
////////////////////
// shared lsu types
// widths come from the lsu config header
////////////////////
`include "lsu_config.svh"

package lsu_pkg;

  //////////////////// vectors
  typedef logic [`LSU_DATA_W-1:0] lsu_word_t; // address or data word
  typedef logic [`LSU_BE_W-1:0]   lsu_be_t;   // one bit per byte lane
  typedef logic [`LSU_OFF_W-1:0]  lsu_off_t;  // byte offset in a word

  // access size as coded by the EX stage
  // 0 word, 1 halfword, 2 and 3 byte
  typedef logic [1:0] lsu_size_t;

  //////////////////// controller states
  typedef enum logic [1:0] {
    IDLE,                 // no access pending
    WAIT_RVALID,          // granted, waiting for read/write response
    WAIT_RVALID_EX_STALL, // granted while EX was stalled
    IDLE_EX_STALL         // response seen, EX still stalled
  } lsu_state_e;

endpackage

//--- verilog/lsu_req_align.sv
////////////////////
// request side of the lsu, all paths combinational from the EX inputs
// bytes are never misaligned, only words and offset-3 halfwords are split
////////////////////
`timescale 1ns/1ps

module lsu_req_align (
  input  lsu_pkg::lsu_word_t operand_a_i,     // base address
  input  lsu_pkg::lsu_word_t operand_b_i,     // increment
  input  logic               addr_useincr_i,  // address is a + b
  input  logic               data_req_i,      // EX wants an access
  input  logic               misaligned_ex_i, // this is phase two of a split access
  input  lsu_pkg::lsu_size_t data_type_i,     // word, halfword or byte
  input  lsu_pkg::lsu_word_t wdata_i,         // store data as held in the register
  input  lsu_pkg::lsu_off_t  reg_offset_i,    // byte offset of the data in the register

  output lsu_pkg::lsu_word_t addr_o,
  output lsu_pkg::lsu_be_t   be_o,
  output lsu_pkg::lsu_word_t wdata_o,
  output logic               misaligned_o     // first phase of a split access
);

  lsu_pkg::lsu_off_t addr_off;  // byte offset of the access
  lsu_pkg::lsu_off_t wdata_off; // store rotation in bytes
  logic [63:0]       wdata_dbl; // store word twice, upper half is the rotated word

  //////////////////// address
  assign addr_o   = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_off = addr_o[1:0];

  //////////////////// byte enables
  // phase one covers the lanes from the offset upward,
  // phase two covers what spilled into the next word
  always_comb
  begin
    case (data_type_i)
      2'b00:
      begin
        if (misaligned_ex_i)
          be_o = (4'b0001 << addr_off) - 4'b0001; // lanes below the offset
        else
          be_o = 4'b1111 << addr_off;             // offset and up, all four if aligned
      end

      2'b01:
      begin
        if (misaligned_ex_i)
          be_o = 4'b0001;              // only the top byte spills into lane 0
        else
          be_o = 4'b0011 << addr_off;  // offset 3 keeps lane 3 only
      end

      default:
      begin
        be_o = 4'b0001 << addr_off;    // single byte lane
      end
    endcase
  end

  //////////////////// store data
  // the register offset says where the data sits in the source register,
  // so the rotation is by the difference of the two offsets
  assign wdata_off = addr_off - reg_offset_i;
  assign wdata_dbl = {wdata_i, wdata_i} << {wdata_off, 3'b000}; // rotate left by bytes
  assign wdata_o   = wdata_dbl[63:32];

  //////////////////// misalignment
  // flagged in phase one only, EX then issues phase two at the next word
  always_comb
  begin
    misaligned_o = 1'b0;

    if (data_req_i && !misaligned_ex_i)
    begin
      if (data_type_i == 2'b00)
        misaligned_o = (addr_off != 2'b00); // word off a word boundary
      else if (data_type_i == 2'b01)
        misaligned_o = (addr_off == 2'b11); // halfword crossing the word
    end
  end

endmodule

//--- verilog/lsu_top.sv
////////////////////
// lsu top, memory port on one side and EX stage on the other
// split accesses need EX to issue the second phase itself
////////////////////
`timescale 1ns/1ps

module lsu_top (
  input  logic               clk,
  input  logic               rst_n,

  // memory port
  output logic               data_req_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               data_err_i,
  output lsu_pkg::lsu_word_t data_addr_o,
  output logic               data_we_o,
  output lsu_pkg::lsu_be_t   data_be_o,
  output lsu_pkg::lsu_word_t data_wdata_o,
  input  lsu_pkg::lsu_word_t data_rdata_i,

  // EX stage
  input  logic               data_we_ex_i,
  input  lsu_pkg::lsu_size_t data_type_ex_i,
  input  lsu_pkg::lsu_word_t data_wdata_ex_i,
  input  lsu_pkg::lsu_off_t  data_reg_offset_ex_i,
  input  logic               data_sign_ext_ex_i,
  output lsu_pkg::lsu_word_t data_rdata_ex_o,
  input  logic               data_req_ex_i,
  input  lsu_pkg::lsu_word_t operand_a_ex_i,
  input  lsu_pkg::lsu_word_t operand_b_ex_i,
  input  logic               addr_useincr_ex_i,
  input  logic               data_misaligned_ex_i, // phase two in progress
  output logic               data_misaligned_o,    // phase one, second access needed

  output logic               load_err_o,
  output logic               store_err_o,
  output logic               lsu_ready_ex_o,
  output logic               lsu_ready_wb_o,
  input  logic               ex_valid_i,
  output logic               busy_o
);

  lsu_pkg::lsu_off_t addr_off; // low address bits for the load side

  assign addr_off  = data_addr_o[1:0];
  assign data_we_o = data_we_ex_i; // write enable goes straight out

  lsu_req_align u_req_align (
    .operand_a_i     (operand_a_ex_i),
    .operand_b_i     (operand_b_ex_i),
    .addr_useincr_i  (addr_useincr_ex_i),
    .data_req_i      (data_req_ex_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .data_type_i     (data_type_ex_i),
    .wdata_i         (data_wdata_ex_i),
    .reg_offset_i    (data_reg_offset_ex_i),
    .addr_o          (data_addr_o),
    .be_o            (data_be_o),
    .wdata_o         (data_wdata_o),
    .misaligned_o    (data_misaligned_o)
  );

  lsu_load_align u_load_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .addr_off_i      (addr_off),
    .data_type_i     (data_type_ex_i),
    .sign_ext_i      (data_sign_ext_ex_i),
    .data_we_i       (data_we_ex_i),
    .misaligned_ex_i (data_misaligned_ex_i),
    .misaligned_o_i  (data_misaligned_o),
    .data_rdata_i    (data_rdata_i),
    .rdata_o         (data_rdata_ex_o)
  );

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_req_ex_i   (data_req_ex_i),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .data_we_i       (data_we_ex_i),
    .ex_valid_i      (ex_valid_i),
    .data_req_o      (data_req_o),
    .lsu_ready_ex_o  (lsu_ready_ex_o),
    .lsu_ready_wb_o  (lsu_ready_wb_o),
    .busy_o          (busy_o),
    .load_err_o      (load_err_o),
    .store_err_o     (store_err_o)
  );

endmodule
